/* hw/rv_pkg.sv */
// RV64I core shared definitions
package rv_pkg;

	// Datapath widths
	localparam int xlen       = 64;                 // Register and ALU width
	localparam int reg_addr_w = 5;                  // Register index width, 32 registers
	localparam int imm_w      = 12;                 // I-type immediate width
	localparam int shamt_w    = 6;                  // RV64 shift amount bits

	// Major opcodes of the two supported groups
	localparam logic [6:0] op_reg = 7'b0110011;     // Register-register ALU
	localparam logic [6:0] op_imm = 7'b0010011;     // Register-immediate ALU

	// funct3 encodings, shared by both groups where defined
	localparam logic [2:0] f3_add = 3'b000;         // ADD, SUB, ADDI
	localparam logic [2:0] f3_sll = 3'b001;         // SLL
	localparam logic [2:0] f3_slt = 3'b010;         // SLT, SLTI
	localparam logic [2:0] f3_xor = 3'b100;         // XOR, XORI
	localparam logic [2:0] f3_srl = 3'b101;         // SRL
	localparam logic [2:0] f3_or  = 3'b110;         // OR, ORI
	localparam logic [2:0] f3_and = 3'b111;         // AND, ANDI

	// funct7 alternate encoding, only bit 5 is meaningful here
	localparam logic [6:0] f7_alt = 7'b0100000;     // Selects SUB over ADD

	// ALU operations, exactly eight so three bits are fully used
	typedef enum logic [2:0] {
		alu_add,                                    // a + b
		alu_sub,                                    // a - b
		alu_and,                                    // a & b
		alu_or,                                     // a | b
		alu_xor,                                    // a ^ b
		alu_sll,                                    // a << b[5:0]
		alu_srl,                                    // a >> b[5:0], logical
		alu_slt                                     // Signed a < b
	} alu_op_e;

	// Register-register view of the instruction word
	typedef struct packed {
		logic [6:0]            funct7;              // Operation modifier
		logic [reg_addr_w-1:0] rs2;                 // Second source
		logic [reg_addr_w-1:0] rs1;                 // First source
		logic [2:0]            funct3;              // Operation select
		logic [reg_addr_w-1:0] rd;                  // Destination
		logic [6:0]            opcode;              // Major opcode
	} r_type_s;

	// Register-immediate view of the same word
	typedef struct packed {
		logic [imm_w-1:0]      imm12;               // Signed immediate
		logic [reg_addr_w-1:0] rs1;                 // Source
		logic [2:0]            funct3;              // Operation select
		logic [reg_addr_w-1:0] rd;                  // Destination
		logic [6:0]            opcode;              // Major opcode
	} i_type_s;

	// One 32-bit word, read either way depending on the opcode
	typedef union packed {
		r_type_s r;                                 // ADD, SUB, AND, ...
		i_type_s i;                                 // ADDI, ANDI, ...
	} rv_inst_u;

endpackage

/* hw/rf_read_if.sv */
// Register file read ports
interface rf_read_if;

	// Port 1, always used for rs1
	logic [rv_pkg::reg_addr_w-1:0] r_addr1;         // Read index
	logic                          r_ena1;          // Read enable, zero data when low
	logic [rv_pkg::xlen-1:0]       r_data1;         // Read data

	// Port 2, only used by register-register instructions
	logic [rv_pkg::reg_addr_w-1:0] r_addr2;         // Read index
	logic                          r_ena2;          // Read enable, zero data when low
	logic [rv_pkg::xlen-1:0]       r_data2;         // Read data

	// Register file side returns data
	modport rf (
		input  r_addr1, r_ena1, r_addr2, r_ena2,
		output r_data1, r_data2
	);

	// Decoder side issues addresses
	modport dec (
		output r_addr1, r_ena1, r_addr2, r_ena2,
		input  r_data1, r_data2
	);

endinterface

/* hw/inst_queue.sv */
// Credited instruction queue
module inst_queue #(
	parameter int queue_depth = 4                    // Entries, equals source credits
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,               // Credited push, never overflows
	input  rv_pkg::rv_inst_u in_inst,
	input  logic             take,                   // Decoder consumes head
	output logic             head_valid,
	output rv_pkg::rv_inst_u head_inst,
	output logic             credit_return           // One credit per pop
);

	localparam int ptr_w = $clog2(queue_depth);      // Index width
	localparam int cnt_w = $clog2(queue_depth + 1);  // Occupancy holds 0..queue_depth

	rv_pkg::rv_inst_u mem [queue_depth];             // Entry storage
	logic [ptr_w-1:0] wr_ptr;                        // Next free slot
	logic [ptr_w-1:0] rd_ptr;                        // Current head
	logic [cnt_w-1:0] count;                         // Occupancy
	logic             pop;                           // Head leaves this cycle

	// Wrap at queue_depth so non power of two depths work
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head_valid    = (count != '0);            // Not empty
	assign head_inst     = mem[rd_ptr];              // Head visible a cycle after push
	assign pop           = take && head_valid;
	assign credit_return = pop;                      // Slot freed in the same cycle

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_inst;                  // Payload only
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;                            // Empty after reset
		end
		else
		begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;      // Push only
				2'b01:   count <= count - 1'b1;      // Pop only
				default: count <= count;             // Both or neither
			endcase
		end
	end

endmodule

/* hw/regfile.sv */
// Integer register file
module regfile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          w_ena,     // Writeback valid
	input  logic [rv_pkg::reg_addr_w-1:0] w_addr,    // Writeback index
	input  logic [rv_pkg::xlen-1:0]       w_data,    // Writeback value
	rf_read_if.rf                         rd         // Two read ports
);

	localparam int nregs = 2 ** rv_pkg::reg_addr_w;  // 32 registers

	logic [rv_pkg::xlen-1:0] regs [nregs];           // x0 slot stays zero

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;                       // Architectural reset to zero
		end
		else if (w_ena && (w_addr != '0))
		begin
			regs[w_addr] <= w_data;                  // Writes to x0 dropped
		end
	end

	// Reads are combinational, the decoder samples them in the same cycle
	always_comb
	begin
		rd.r_data1 = '0;                             // Disabled or x0
		if (rd.r_ena1 && (rd.r_addr1 != '0))
		begin
			if (w_ena && (w_addr == rd.r_addr1))
				rd.r_data1 = w_data;                 // Bypass the write in flight
			else
				rd.r_data1 = regs[rd.r_addr1];
		end
	end

	always_comb
	begin
		rd.r_data2 = '0;                             // Disabled or x0
		if (rd.r_ena2 && (rd.r_addr2 != '0))
		begin
			if (w_ena && (w_addr == rd.r_addr2))
				rd.r_data2 = w_data;                 // Bypass the write in flight
			else
				rd.r_data2 = regs[rd.r_addr2];
		end
	end

endmodule

/* hw/inst_decoder.sv */
// Decode and operand read
module inst_decoder (
	input  logic                          head_valid,  // Queue not empty
	input  rv_pkg::rv_inst_u              head_inst,   // Word at queue head
	output logic                          take,        // Consume head
	rf_read_if.dec                        rd,          // Register reads
	output logic                          dec_valid,
	output rv_pkg::alu_op_e               dec_op,
	output logic [rv_pkg::reg_addr_w-1:0] dec_rd,
	output logic [rv_pkg::xlen-1:0]       operand_a,
	output logic [rv_pkg::xlen-1:0]       operand_b
);

	logic                    is_reg;                   // Register-register group
	logic                    is_imm;                   // Register-immediate group
	logic [2:0]              funct3;                   // Operation select
	logic                    alt;                      // funct7 bit 5 selects SUB
	logic [rv_pkg::xlen-1:0] imm_sext;                 // Sign-extended imm12

	// Opcode sits at the same bits in both views
	assign is_reg = (head_inst.r.opcode == rv_pkg::op_reg);
	assign is_imm = (head_inst.i.opcode == rv_pkg::op_imm);

	// Execute never stalls, so the head is taken as soon as it shows up
	assign take      = head_valid;
	assign dec_valid = head_valid;

	assign funct3 = head_inst.r.funct3;                // Same bits in both views
	assign alt    = is_reg && ((head_inst.r.funct7 & rv_pkg::f7_alt) != '0);

	assign imm_sext = {{(rv_pkg::xlen - rv_pkg::imm_w){head_inst.i.imm12[rv_pkg::imm_w-1]}},
		head_inst.i.imm12};

	// Register read requests
	assign rd.r_addr1 = head_inst.r.rs1;               // rs1 shared by both views
	assign rd.r_ena1  = head_valid && (is_reg || is_imm);
	assign rd.r_addr2 = head_inst.r.rs2;
	assign rd.r_ena2  = head_valid && is_reg;          // Immediate form has no rs2

	assign dec_rd = head_inst.r.rd;                    // rd shared by both views

	// B operand picks register or immediate
	assign operand_a = rd.r_data1;
	assign operand_b = is_reg ? rd.r_data2 : imm_sext;

	// funct3 plus funct7 bit 5 to ALU operation
	always_comb
	begin
		case (funct3)
			rv_pkg::f3_add: dec_op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			rv_pkg::f3_sll: dec_op = rv_pkg::alu_sll;
			rv_pkg::f3_slt: dec_op = rv_pkg::alu_slt;
			rv_pkg::f3_xor: dec_op = rv_pkg::alu_xor;
			rv_pkg::f3_srl: dec_op = rv_pkg::alu_srl;
			rv_pkg::f3_or:  dec_op = rv_pkg::alu_or;
			rv_pkg::f3_and: dec_op = rv_pkg::alu_and;
			default:        dec_op = rv_pkg::alu_add;  // SLTU etc. not in subset
		endcase
	end

endmodule

/* hw/exec_stage.sv */
// ALU and writeback register
module exec_stage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          dec_valid,    // Instruction in execute
	input  rv_pkg::alu_op_e               dec_op,
	input  logic [rv_pkg::reg_addr_w-1:0] dec_rd,
	input  logic [rv_pkg::xlen-1:0]       operand_a,
	input  logic [rv_pkg::xlen-1:0]       operand_b,
	output logic                          w_ena,        // Register file write port
	output logic [rv_pkg::reg_addr_w-1:0] w_addr,
	output logic [rv_pkg::xlen-1:0]       w_data,
	output logic                          retire_valid, // Retire report, same cycle as write
	output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
	output logic [rv_pkg::xlen-1:0]       retire_data
);

	logic [rv_pkg::shamt_w-1:0]    shamt;               // Low bits of operand B
	logic [rv_pkg::xlen-1:0]       alu_res;             // Combinational result
	logic                          wb_valid;            // Writeback stage occupied
	logic [rv_pkg::reg_addr_w-1:0] wb_rd;
	logic [rv_pkg::xlen-1:0]       wb_data;

	assign shamt = operand_b[rv_pkg::shamt_w-1:0];

	always_comb
	begin
		case (dec_op)
			rv_pkg::alu_add: alu_res = operand_a + operand_b;
			rv_pkg::alu_sub: alu_res = operand_a - operand_b;
			rv_pkg::alu_and: alu_res = operand_a & operand_b;
			rv_pkg::alu_or:  alu_res = operand_a | operand_b;
			rv_pkg::alu_xor: alu_res = operand_a ^ operand_b;
			rv_pkg::alu_sll: alu_res = operand_a << shamt;
			rv_pkg::alu_srl: alu_res = operand_a >> shamt;      // Logical, zero fill
			rv_pkg::alu_slt: alu_res = {{(rv_pkg::xlen - 1){1'b0}},
				($signed(operand_a) < $signed(operand_b))};     // Signed compare
			default:         alu_res = operand_a + operand_b;
		endcase
	end

	// Valid bit is control, cleared on reset
	always_ff @(posedge clk)
	begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= dec_valid;
	end

	// Payload captured only for a real instruction
	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			wb_rd   <= dec_rd;
			wb_data <= alu_res;
		end
	end

	// One register feeds both the write port and the retire report
	assign w_ena  = wb_valid;
	assign w_addr = wb_rd;
	assign w_data = wb_data;

	// rd x0 still retires its computed value, the register file drops it
	assign retire_valid = wb_valid;
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_data;

endmodule

/* hw/rv_core.sv */
// RV64I integer core top
module rv_core #(
	parameter int queue_depth = 4                       // Queue slots and initial credits
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          inst_valid,    // Credited instruction
	input  logic [31:0]                   inst,
	output logic                          credit_return, // One credit back per pulse
	output logic                          retire_valid,
	output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
	output logic [rv_pkg::xlen-1:0]       retire_data
);

	logic                          head_valid;           // Queue to decoder
	rv_pkg::rv_inst_u              head_inst;
	logic                          take;
	logic                          dec_valid;            // Decoder to execute
	rv_pkg::alu_op_e               dec_op;
	logic [rv_pkg::reg_addr_w-1:0] dec_rd;
	logic [rv_pkg::xlen-1:0]       operand_a;
	logic [rv_pkg::xlen-1:0]       operand_b;
	logic                          w_ena;                // Execute to register file
	logic [rv_pkg::reg_addr_w-1:0] w_addr;
	logic [rv_pkg::xlen-1:0]       w_data;

	rf_read_if rf_rd ();                                 // Both read ports

	inst_queue #(
		.queue_depth(queue_depth)
	) queue_i (
		.clk(clk), .rst(rst),
		.in_valid(inst_valid), .in_inst(inst),           // Raw word viewed as union
		.take(take), .head_valid(head_valid), .head_inst(head_inst),
		.credit_return(credit_return)
	);

	inst_decoder decoder_i (
		.head_valid(head_valid), .head_inst(head_inst), .take(take),
		.rd(rf_rd.dec),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	regfile regfile_i (
		.clk(clk), .rst(rst),
		.w_ena(w_ena), .w_addr(w_addr), .w_data(w_data),
		.rd(rf_rd.rf)
	);

	exec_stage exec_i (
		.clk(clk), .rst(rst),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.operand_a(operand_a), .operand_b(operand_b),
		.w_ena(w_ena), .w_addr(w_addr), .w_data(w_data),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

endmodule

/* verif/rv_core_chk.sv */
// Retire and credit checker
module rv_core_chk #(
	parameter int queue_depth = 4                    // Credits the source starts with
) (
	input logic                          clk,
	input logic                          rst,
	input logic                          inst_valid,
	input logic [31:0]                   inst,
	input logic                          credit_return,
	input logic                          retire_valid,
	input logic [rv_pkg::reg_addr_w-1:0] retire_rd,
	input logic [rv_pkg::xlen-1:0]       retire_data
);

	logic [31:0]             issued [16];            // Issued, not yet retired
	logic [3:0]              wr_ptr;
	logic [3:0]              rd_ptr;                 // Oldest issued instruction
	int                      outstanding;            // Credits in use
	logic                    issued_any;             // Any issue since reset
	logic [rv_pkg::xlen-1:0] shadow [32];            // Architectural register model
	logic                    failed = 1'b0;          // Sticky, watched by the testbench
	rv_pkg::rv_inst_u        head;
	logic                    is_reg;
	logic [rv_pkg::xlen-1:0] a;
	logic [rv_pkg::xlen-1:0] b;
	logic [rv_pkg::xlen-1:0] exp_data;               // Result the oldest one must retire

	task automatic flag_failure(input string msg);
		failed = 1'b1;
		$error("%s", msg);
	endtask

	assign head   = issued[rd_ptr];
	assign is_reg = (head.r.opcode == rv_pkg::op_reg);

	// RV64I rules on the model state
	always_comb
	begin
		a = shadow[head.r.rs1];                      // rs1 at the same bits in both views
		b = is_reg ? shadow[head.r.rs2] : {{52{head.i.imm12[11]}}, head.i.imm12};
		case (head.r.funct3)
			rv_pkg::f3_add: exp_data = (is_reg && head.r.funct7[5]) ? a - b : a + b;
			rv_pkg::f3_sll: exp_data = a << b[5:0];
			rv_pkg::f3_slt: exp_data = {63'd0, $signed(a) < $signed(b)};
			rv_pkg::f3_xor: exp_data = a ^ b;
			rv_pkg::f3_srl: exp_data = a >> b[5:0];
			rv_pkg::f3_or:  exp_data = a | b;
			default:        exp_data = a & b;        // AND, ANDI
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			outstanding <= 0;
			issued_any  <= 1'b0;
			for (int i = 0; i < 32; i++)
				shadow[i] <= '0;                     // Reset clears the model too
		end
		else
		begin
			if (inst_valid)
			begin
				issued[wr_ptr] <= inst;
				wr_ptr         <= wr_ptr + 4'd1;
				issued_any     <= 1'b1;
			end
			if (retire_valid)
			begin
				rd_ptr <= rd_ptr + 4'd1;
				if (head.r.rd != '0)
					shadow[head.r.rd] <= exp_data;   // x0 never changes
			end
			outstanding <= outstanding + int'(inst_valid) - int'(credit_return);
		end
	end

	a_quiet: assert property (@(posedge clk) disable iff (rst)
		!issued_any |-> !credit_return && !retire_valid)
		else flag_failure("credit or retire seen before any issue");
	a_owed: assert property (@(posedge clk) disable iff (rst) credit_return |-> outstanding != 0)
		else flag_failure("credit returned with no instruction outstanding");
	a_spent: assert property (@(posedge clk) disable iff (rst)
		inst_valid |-> outstanding < queue_depth)
		else flag_failure("instruction issued without a credit");
	a_lat_fwd: assert property (@(posedge clk) disable iff (rst) $past(credit_return) |-> retire_valid)
		else flag_failure("no retire one cycle after a credit return");
	a_lat_back: assert property (@(posedge clk) disable iff (rst) retire_valid |-> $past(credit_return))
		else flag_failure("retire without a credit return one cycle before");
	a_rd: assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_rd == head.r.rd)
		else flag_failure($sformatf("Error retire_rd %h expected %h", retire_rd, head.r.rd));
	a_data: assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_data == exp_data)
		else flag_failure($sformatf("Error retire_data %h expected %h", retire_data, exp_data));

endmodule

bind rv_core rv_core_chk #(
	.queue_depth(queue_depth)
) chk_i (
	.clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
	.credit_return(credit_return), .retire_valid(retire_valid),
	.retire_rd(retire_rd), .retire_data(retire_data)
);

/* verif/rv_core_tb.sv */
// RV64I core testbench
module rv_core_tb;

	localparam int queue_depth = 4;                  // Queue slots and initial credits
	localparam int n_random    = 200;                // Random instructions after directed ones
	localparam int max_wait    = 1000;               // Cycle limit of any wait

	logic        clk        = 1'b0;
	logic        rst        = 1'b1;
	logic        inst_valid = 1'b0;
	logic [31:0] inst       = '0;
	logic        credit_return;
	logic        retire_valid;
	logic [4:0]  retire_rd;
	logic [63:0] retire_data;
	int          credits;                            // Credits the source holds
	logic [31:0] rnd = 32'd20119;                    // xorshift state

	rv_core #(
		.queue_depth(queue_depth)
	) dut_i (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
		.credit_return(credit_return), .retire_valid(retire_valid),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	always #20 clk = ~clk;                           // 40 unit period

	task automatic stop_fail(input string why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	// Assertions fire at the rising edge, picked up half a cycle later
	always @(negedge clk)
	begin
		if (dut_i.chk_i.failed)
			stop_fail("checker assertion failed");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] r_type_word(input logic [2:0] f3, input logic alt,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {alt ? rv_pkg::f7_alt : 7'd0, rs2, rs1, f3, rd, rv_pkg::op_reg};
	endfunction

	function automatic logic [31:0] i_type_word(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, rv_pkg::op_imm};
	endfunction

	// One clock, with the credit count following what happened in that cycle
	task automatic step();
		@(posedge clk);
		credits = credits + int'(credit_return) - int'(inst_valid);
	endtask

	task automatic apply_reset(input int cycles);
		rst        <= 1'b1;
		inst_valid <= 1'b0;
		repeat (cycles) @(posedge clk);
		rst     <= 1'b0;
		credits = queue_depth;                       // Queue empty again
	endtask

	task automatic idle();
		inst_valid <= 1'b0;
		step();
	endtask

	task automatic issue(input logic [31:0] word);
		int waited;
		waited = 0;
		while (credits == 0)
		begin
			inst_valid <= 1'b0;                      // Hold off until a credit comes back
			step();
			waited++;
			if (waited > max_wait)
				stop_fail("no credit came back while waiting to issue");
		end
		inst_valid <= 1'b1;
		inst       <= word;
		step();
	endtask

	// All credits home and the last retire gone by
	task automatic drain();
		int waited;
		waited = 0;
		idle();
		while (credits != queue_depth || credit_return || retire_valid)
		begin
			step();
			waited++;
			if (waited > max_wait)
				stop_fail("credits did not all return at the end of the program");
		end
	endtask

	initial
	begin
		logic [2:0] f3;
		apply_reset(10);
		issue(i_type_word(rv_pkg::f3_add, 5'd1, 5'd0, 12'h005));   // x1 = 5
		issue(i_type_word(rv_pkg::f3_add, 5'd2, 5'd0, 12'hffd));   // x2 = -3, bypassed
		issue(r_type_word(rv_pkg::f3_add, 1'b0, 5'd3, 5'd1, 5'd2));
		issue(r_type_word(rv_pkg::f3_add, 1'b1, 5'd4, 5'd1, 5'd2)); // SUB
		issue(r_type_word(rv_pkg::f3_and, 1'b0, 5'd5, 5'd1, 5'd2));
		issue(r_type_word(rv_pkg::f3_or, 1'b0, 5'd6, 5'd1, 5'd2));
		issue(r_type_word(rv_pkg::f3_xor, 1'b0, 5'd7, 5'd1, 5'd2));
		issue(r_type_word(rv_pkg::f3_sll, 1'b0, 5'd8, 5'd1, 5'd2)); // Shift by 61
		issue(r_type_word(rv_pkg::f3_srl, 1'b0, 5'd9, 5'd2, 5'd1));
		issue(r_type_word(rv_pkg::f3_slt, 1'b0, 5'd10, 5'd2, 5'd1)); // -3 < 5
		issue(i_type_word(rv_pkg::f3_and, 5'd11, 5'd2, 12'h0f0));
		issue(i_type_word(rv_pkg::f3_or, 5'd12, 5'd1, 12'h800));
		issue(i_type_word(rv_pkg::f3_xor, 5'd13, 5'd2, 12'h555));
		issue(i_type_word(rv_pkg::f3_slt, 5'd14, 5'd1, 12'hfff));
		for (int k = 0; k < 6; k++)
			issue(i_type_word(rv_pkg::f3_add, 5'd15, 5'd15, 12'h123)); // Chain on x15
		issue(r_type_word(rv_pkg::f3_add, 1'b0, 5'd16, 5'd15, 5'd15));
		issue(i_type_word(rv_pkg::f3_add, 5'd0, 5'd1, 12'h007));   // Retires 12, x0 kept
		issue(i_type_word(rv_pkg::f3_add, 5'd17, 5'd0, 12'h800));  // Plain -2048
		drain();
		apply_reset(3);                                            // Mid-program reset
		for (int k = 0; k < 32; k++)
			issue(i_type_word(rv_pkg::f3_add, k[4:0], k[4:0], 12'(64 + k)));
		for (int n = 0; n < n_random; n++)
		begin
			rnd = xorshift(rnd);
			if (rnd[31:30] == 2'b00)
				idle();                                            // Withhold valid
			rnd = xorshift(rnd);
			f3 = rnd[2:0];
			if (rnd[3])
				issue(r_type_word((f3 == 3'b011) ? rv_pkg::f3_add : f3, f3 == 3'b011,
					{1'b0, rnd[23:20]}, {1'b0, rnd[27:24]}, {1'b0, rnd[31:28]}));
			else
			begin
				if (f3 != 3'b111)
					f3[0] = 1'b0;                                  // No shift-immediate or SLTIU
				issue(i_type_word(f3, {1'b0, rnd[23:20]}, {1'b0, rnd[27:24]}, rnd[19:8]));
			end
		end
		drain();
		if (dut_i.chk_i.failed)
			stop_fail("checker assertion failed");
		else
		begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* sim.f */
hw/rv_pkg.sv
hw/rf_read_if.sv
hw/inst_queue.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/exec_stage.sv
hw/rv_core.sv
verif/rv_core_chk.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sim.f --top-module rv_core_tb \
	-Mdir obj_dir -o rv_core_sim \
	&& ./obj_dir/rv_core_sim +verilator+error+limit+100 | tee /dev/stderr \
	| grep -qx "TEST PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail" >&2; exit 1; }
